//--- bpi_ctrl.f
logic/bpi_pkg.sv
logic/cmd_fifo.sv
logic/cmd_parser.sv
logic/prom_sequencer.sv
logic/prom_cmd_map.sv
logic/status_regs.sv
logic/bpi_ctrl.sv
tb/clk_gen.sv
tb/bpi_ctrl_properties.sv
tb/bpi_ctrl_tb.sv

//--- Bender.yml
package:
  name: bpi_ctrl

sources:
  - logic/bpi_pkg.sv
  - logic/cmd_fifo.sv
  - logic/cmd_parser.sv
  - logic/prom_sequencer.sv
  - logic/prom_cmd_map.sv
  - logic/status_regs.sv
  - logic/bpi_ctrl.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/bpi_ctrl_properties.sv
      - tb/bpi_ctrl_tb.sv

//--- tb/bpi_ctrl_tb.sv
`timescale 1ns/1ns

module bpi_ctrl_tb;
	import bpi_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_CMDS   = 20;    // Commands issued over all tests
	localparam logic [31:0] SEED = 32'h7b8400cb;

	logic CLK, local_rst, bpi_we, bpi_re, bpi_enbl, bpi_dsbl;
	logic bpi_busy, bpi_load_data, bpi_active, bpi_cfg_done, bpi_execute;
	cmd_word_t bpi_cmd_fifo_data, bpi_rbk_fifo_data;
	prom_data_t bpi_data_from, bpi_data_to;
	fifo_cnt_t bpi_rbk_wrd_cnt;
	logic [15:0] bpi_status;
	bus_op_t bpi_op;
	prom_addr_t bpi_addr;

	// PROM model state
	prom_data_t mem [prom_addr_t];
	logic status_mode, erase_armed, prog_armed;
	int polls_left;
	sr_t inject_sr;
	logic [31:0] fill_key;
	// Reference model state
	logic [41:0] exp_cycles [$];      // {poll, op, addr, data}
	cmd_word_t rbk_exp [$];
	logic [6:0] ref_base;
	prom_data_t ref_off, pdata;
	sr_t ref_sr;
	logic ref_prom_err, ref_rd_err;
	int errors, n;

	clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.CLK(CLK));

	bpi_ctrl uut (.*);

	function automatic prom_data_t mem_value(input prom_addr_t a);
		logic [31:0] h;
		if (mem.exists(a))
			return mem[a];
		h = ({9'd0, a} * 32'h9E3779B1) ^ fill_key;  // Default fill from the whole address
		return h[31:16] ^ h[15:0];
	endfunction

	function automatic prom_addr_t cur_addr();
		return {ref_base, ref_off};
	endfunction

	// 16 KWord blocks in the top 64 KWords and 64 KWord blocks below
	function automatic prom_addr_t block_of(input prom_addr_t a);
		if (a[22:16] == 7'h7F)
			return {a[22:14], 14'd0};
		return {a[22:16], 16'd0};
	endfunction

	// Host status word once the queue has finished
	function automatic logic [15:0] expected_status();
		logic [15:0] s;
		s = '0;
		s[ST_RBK_EMPTY] = (rbk_exp.size() == 0);
		s[ST_RBK_RDERR] = ref_rd_err;
		s[ST_CMD_EMPTY] = 1'b1;
		s[ST_PROM_ERR]  = ref_prom_err;
		s[7:0]          = ref_sr;
		return s;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			errors++;
			$display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic tick();
		@(posedge CLK);
		#5;                                // Drive and sample off the edge
	endtask

	//////////////////////////////////////////////////
	// PROM behavioral model
	//////////////////////////////////////////////////

	task automatic prom_write(input prom_addr_t a, input prom_data_t d);
		if (prog_armed || (erase_armed && d == OPC_CONFIRM))
		begin
			if (prog_armed)
				mem[a] = d;
			prog_armed  = 1'b0;
			erase_armed = 1'b0;
			status_mode = 1'b1;
			polls_left  = $urandom % 4;    // Not ready for a few polls
		end
		else
			case (d)
				OPC_READ_ARRAY:  status_mode = 1'b0;
				OPC_READ_SR:     status_mode = 1'b1;
				OPC_ERASE_SETUP: erase_armed = 1'b1;
				OPC_PROGRAM:     prog_armed = 1'b1;
				default:         status_mode = status_mode;
			endcase
	endtask

	task automatic serve_cycle();
		logic [41:0] exp;
		bus_op_t op;
		prom_addr_t a;
		prom_data_t wd, rd;
		logic ready;
		int len, load_at, i;
		op = bpi_op;
		a = bpi_addr;
		wd = bpi_data_to;
		ready = 1'b1;
		rd = '0;
		if (op != OP_READ)
			prom_write(a, wd);
		else if (!status_mode)
			rd = mem_value(a);
		else if (polls_left > 0)
		begin
			polls_left--;
			ready = 1'b0;
		end
		else
			rd = {8'h00, 8'h80 | inject_sr};
		if (exp_cycles.size() == 0)
		begin
			errors++;
			$display("Bus cycle at %0t was issued when none was expected", $time);
		end
		else
		begin
			exp = exp_cycles[0];
			check_eq("bpi_op", exp[40:39], op);
			check_eq("bpi_addr", exp[38:16], a);
			if (op == OP_WRITE)
				check_eq("bpi_data_to", exp[15:0], wd);
			if (exp[41])
				ref_sr = rd[7:0];          // Every poll reloads the status copy
			if (!exp[41] || ready)
				void'(exp_cycles.pop_front());  // Polls repeat until ready
		end
		len = 1 + $urandom % 6;
		load_at = $urandom % len;
		for (i = 0; i < len; i++)
		begin
			tick();
			bpi_busy = 1'b1;
			bpi_load_data = (op == OP_READ) && (i == load_at);
			bpi_data_from = bpi_load_data ? rd : prom_data_t'($urandom);
		end
		tick();
		bpi_busy = 1'b0;
		bpi_load_data = 1'b0;
	endtask

	task automatic serve_loop();
		forever
		begin
			tick();
			if (!local_rst && bpi_execute)
				serve_cycle();
		end
	endtask

	//////////////////////////////////////////////////
	// Host commands and reference model
	//////////////////////////////////////////////////

	task automatic send_word(input cmd_word_t w);
		bpi_cmd_fifo_data = w;
		bpi_we = 1'b1;
		tick();
		bpi_we = 1'b0;
	endtask

	task automatic expect_cycle(input logic poll, input bus_op_t op, input prom_addr_t a,
		input prom_data_t d);
		exp_cycles.push_back({poll, op, a, d});
	endtask

	task automatic cmd_load_addr(input logic [6:0] base, input prom_data_t off);
		send_word({4'd0, base, CMD_LOAD_ADDR});
		send_word(off);
		ref_base = base;
		ref_off = off;
	endtask

	task automatic cmd_read_array();
		send_word({11'd0, CMD_READ_ARRAY});
		expect_cycle(1'b0, OP_WRITE, cur_addr() & BANK_MASK, OPC_READ_ARRAY);
	endtask

	task automatic cmd_read(input int cnt);
		int i;
		send_word({cmd_arg_t'(cnt - 1), (cnt == 1) ? CMD_READ_1 : CMD_READ_N});
		for (i = 0; i < cnt; i++)
		begin
			expect_cycle(1'b0, OP_READ, cur_addr(), 16'h0);
			rbk_exp.push_back(mem_value(cur_addr()));
			ref_off++;                     // Offset wraps at 16 bits
		end
	endtask

	task automatic cmd_erase();
		prom_addr_t blk;
		blk = block_of(cur_addr());
		send_word({11'd0, CMD_BLOCK_ERASE});
		expect_cycle(1'b0, OP_WRITE, blk, OPC_ERASE_SETUP);
		expect_cycle(1'b0, OP_WRITE, blk, OPC_CONFIRM);
		expect_cycle(1'b1, OP_READ, blk, 16'h0);
	endtask

	task automatic cmd_program(input prom_data_t d);
		send_word({11'd0, CMD_PROGRAM});
		send_word(d);
		expect_cycle(1'b0, OP_WRITE, cur_addr(), OPC_PROGRAM);
		expect_cycle(1'b0, OP_WRITE, cur_addr(), d);
		expect_cycle(1'b1, OP_READ, cur_addr(), 16'h0);
		ref_off++;
	endtask

	task automatic wait_idle();
		tick();
		while (!(bpi_cfg_done && !bpi_active))
			tick();
		tick();
		tick();                            // Status word lags by a cycle
		if (exp_cycles.size() != 0)
		begin
			errors++;
			$display("At %0t, %0d expected bus cycles were never issued", $time,
				exp_cycles.size());
			exp_cycles.delete();
		end
		check_eq("bpi_status", expected_status(), bpi_status);
	endtask

	task automatic pulse_re();
		bpi_re = 1'b1;
		tick();
		bpi_re = 1'b0;
	endtask

	task automatic drain_rbk();
		while (rbk_exp.size() > 0)
		begin
			check_eq("bpi_rbk_wrd_cnt", rbk_exp.size(), bpi_rbk_wrd_cnt);
			check_eq("bpi_rbk_fifo_data", rbk_exp.pop_front(), bpi_rbk_fifo_data);
			pulse_re();
		end
		check_eq("bpi_rbk_wrd_cnt", 0, bpi_rbk_wrd_cnt);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial
	begin
		void'($urandom(SEED));
		fill_key = $urandom;
		{bpi_we, bpi_re, bpi_enbl, bpi_dsbl, bpi_busy, bpi_load_data} = '0;
		bpi_cmd_fifo_data = '0;
		bpi_data_from = '0;
		{status_mode, erase_armed, prog_armed, inject_sr} = '0;
		{ref_sr, ref_prom_err, ref_rd_err} = '0;
		polls_left = 0;
		errors = 0;
		local_rst = 1'b1;
		repeat (4)
			@(posedge CLK);
		#5;
		local_rst = 1'b0;
		fork
			serve_loop();
		join_none
		bpi_enbl = 1'b1;
		tick();
		bpi_enbl = 1'b0;

		// Burst read from a random address
		cmd_load_addr(7'($urandom), prom_data_t'($urandom));
		cmd_read_array();
		n = 1 + $urandom % 40;
		cmd_read(n);
		wait_idle();
		check_eq("bpi_rbk_wrd_cnt", n, bpi_rbk_wrd_cnt);
		drain_rbk();

		// Program then read the word back
		cmd_load_addr(7'($urandom), prom_data_t'($urandom));
		pdata = prom_data_t'($urandom);
		cmd_program(pdata);
		wait_idle();
		cmd_load_addr(ref_base, ref_off - 16'd1);
		cmd_read_array();
		rbk_exp.push_back(pdata);
		send_word({11'd0, CMD_READ_1});
		expect_cycle(1'b0, OP_READ, cur_addr(), 16'h0);
		ref_off++;
		wait_idle();
		drain_rbk();

		// Erase in the main and the parameter region
		inject_sr = sr_t'($urandom % 2);   // Bit 0 is no erase error
		cmd_load_addr(7'($urandom % 127), prom_data_t'($urandom));
		cmd_erase();
		cmd_load_addr(7'h7F, prom_data_t'($urandom));
		cmd_erase();
		wait_idle();
		check_eq("bpi_status[7:0]", 8'h80 | inject_sr, bpi_status[7:0]);
		check_eq("bpi_status[9]", 0, bpi_status[ST_PROM_ERR]);

		// Program error is sticky until cleared
		inject_sr = 8'h10;
		ref_prom_err = 1'b1;               // Bit 4 is a program error
		cmd_load_addr(7'($urandom), prom_data_t'($urandom));
		cmd_program(prom_data_t'($urandom));
		wait_idle();
		inject_sr = 8'h00;
		check_eq("bpi_status[9]", 1, bpi_status[ST_PROM_ERR]);
		check_eq("bpi_status[7:0]", 8'h90, bpi_status[7:0]);
		cmd_read_array();
		wait_idle();
		check_eq("bpi_status[9]", 1, bpi_status[ST_PROM_ERR]);
		send_word({11'd0, CMD_CLR_STATUS});
		ref_prom_err = 1'b0;
		wait_idle();
		check_eq("bpi_status[9]", 0, bpi_status[ST_PROM_ERR]);

		// Queue held while parsing is disabled
		bpi_dsbl = 1'b1;
		tick();
		bpi_dsbl = 1'b0;
		cmd_read_array();
		cmd_read(1);
		repeat (20)
		begin
			tick();
			if (bpi_execute)
			begin
				errors++;
				$display("Bus cycle at %0t while parsing was disabled", $time);
			end
			check_eq("bpi_cfg_done", 0, bpi_cfg_done);
		end
		bpi_enbl = 1'b1;
		tick();
		bpi_enbl = 1'b0;
		tick();
		check_eq("bpi_active", 1, bpi_active);
		wait_idle();
		drain_rbk();

		// Readback underflow and empty flag timing
		pulse_re();
		ref_rd_err = 1'b1;
		check_eq("bpi_status[13]", 1, bpi_status[ST_RBK_RDERR]);
		cmd_read(3);
		wait_idle();
		drain_rbk();
		check_eq("bpi_status[15]", 0, bpi_status[ST_RBK_EMPTY]);
		tick();
		check_eq("bpi_status[15]", 1, bpi_status[ST_RBK_EMPTY]);
		send_word({11'd0, CMD_CLR_STATUS});
		ref_rd_err = 1'b0;
		wait_idle();
		check_eq("bpi_status[13]", 0, bpi_status[ST_RBK_RDERR]);

		errors += uut.u_properties.fail_count;
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the number of commands
	initial
	begin
		#(NUM_CMDS * 200 * CLK_PERIOD);
		$display("Watchdog expired, the command queue never finished");
		errors += uut.u_properties.fail_count + 1;
		$display("Run stopped with %0d errors", errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb/bpi_ctrl_properties.sv
`timescale 1ns/1ns

module bpi_ctrl_properties (
	input logic               CLK,
	input logic               local_rst,
	input logic               bpi_execute,
	input logic               bpi_busy,
	input bpi_pkg::bus_op_t   bpi_op,
	input bpi_pkg::fifo_cnt_t bpi_rbk_wrd_cnt
);
	import bpi_pkg::*;

	int fail_count = 0;  // Assertion failures so far

	// One bus cycle at a time
	exec_not_busy: assert property (@(posedge CLK) disable iff (local_rst)
		!(bpi_execute && bpi_busy))
		else
		begin
			$error("Execute issued while the PROM is busy");
			fail_count++;
		end

	exec_single: assert property (@(posedge CLK) disable iff (local_rst)
		bpi_execute |=> !bpi_execute)
		else
		begin
			$error("Execute held for two cycles");
			fail_count++;
		end

	op_legal: assert property (@(posedge CLK) disable iff (local_rst)
		(bpi_op == OP_READ) || (bpi_op == OP_WRITE))
		else
		begin
			$error("Illegal bus operation code");
			fail_count++;
		end

	rbk_cnt_bound: assert property (@(posedge CLK) disable iff (local_rst)
		bpi_rbk_wrd_cnt <= fifo_cnt_t'(2**FIFO_DEPTH_LOG2))
		else
		begin
			$error("Readback count beyond FIFO depth");
			fail_count++;
		end

endmodule

bind bpi_ctrl bpi_ctrl_properties u_properties (
	.CLK            (CLK),
	.local_rst      (local_rst),
	.bpi_execute    (bpi_execute),
	.bpi_busy       (bpi_busy),
	.bpi_op         (bpi_op),
	.bpi_rbk_wrd_cnt(bpi_rbk_wrd_cnt)
);

//--- tb/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic CLK
);

	initial
	begin
		CLK = 1'b0;
		forever
			#(PERIOD_NS / 2) CLK = ~CLK;  // Free running
	end

endmodule

//--- logic/bpi_ctrl.sv
`timescale 1ns/1ns

module bpi_ctrl (
	input  logic                CLK,
	input  logic                local_rst,
	input  bpi_pkg::cmd_word_t  bpi_cmd_fifo_data,
	input  logic                bpi_we,
	input  logic                bpi_re,
	input  logic                bpi_enbl,
	input  logic                bpi_dsbl,
	input  logic                bpi_busy,
	input  bpi_pkg::prom_data_t bpi_data_from,
	input  logic                bpi_load_data,
	output bpi_pkg::cmd_word_t  bpi_rbk_fifo_data,
	output bpi_pkg::fifo_cnt_t  bpi_rbk_wrd_cnt,
	output logic [15:0]         bpi_status,
	output logic                bpi_active,
	output logic                bpi_cfg_done,
	output bpi_pkg::bus_op_t    bpi_op,
	output bpi_pkg::prom_addr_t bpi_addr,
	output bpi_pkg::prom_data_t bpi_data_to,
	output logic                bpi_execute
);
	import bpi_pkg::*;

	// Command FIFO
	cmd_word_t   cmd_head;
	logic        cmd_empty;
	logic        cmd_full;
	logic        cmd_wr_err;
	logic        cmd_pop;
	// Readback FIFO
	logic        rbk_empty;
	logic        rbk_full;
	logic        rbk_wr_err;
	logic        rbk_rd_err;
	logic        rbk_wr;
	// Parser outputs
	logic        seq_start;
	cmd_code_t   seq_cmd;
	logic [11:0] seq_count;
	prom_data_t  prog_data;
	logic        load_addr;
	logic [6:0]  base_addr;
	prom_data_t  start_offset;
	logic        clr_err;
	// Sequencer outputs
	seq_step_t   step;
	logic        addr_incr;
	logic        sr_load;
	logic        prom_err;
	logic        seq_done;

	assign bpi_cfg_done = cmd_empty;

	//////////////////////////////////////////////////
	// Host side FIFOs
	//////////////////////////////////////////////////

	cmd_fifo u_cmd_fifo (
		.CLK      (CLK),
		.local_rst(local_rst),
		.wr_data  (bpi_cmd_fifo_data),
		.wr_en    (bpi_we),
		.rd_en    (cmd_pop),
		.rd_data  (cmd_head),
		.empty    (cmd_empty),
		.full     (cmd_full),
		.count    (),
		.wr_err   (cmd_wr_err),
		.rd_err   ()           // Parser never pops an empty FIFO
	);

	cmd_fifo u_rbk_fifo (
		.CLK      (CLK),
		.local_rst(local_rst),
		.wr_data  (bpi_data_from),
		.wr_en    (rbk_wr),
		.rd_en    (bpi_re),
		.rd_data  (bpi_rbk_fifo_data),
		.empty    (rbk_empty),
		.full     (rbk_full),
		.count    (bpi_rbk_wrd_cnt),
		.wr_err   (rbk_wr_err),
		.rd_err   (rbk_rd_err)
	);

	//////////////////////////////////////////////////
	// Command processing
	//////////////////////////////////////////////////

	cmd_parser u_cmd_parser (
		.CLK(CLK), .local_rst(local_rst),
		.enbl(bpi_enbl), .dsbl(bpi_dsbl),
		.cmd_head(cmd_head), .cmd_empty(cmd_empty), .seq_done(seq_done),
		.cmd_pop(cmd_pop), .active(bpi_active),
		.seq_start(seq_start), .seq_cmd(seq_cmd), .seq_count(seq_count),
		.prog_data(prog_data), .load_addr(load_addr), .base_addr(base_addr),
		.start_offset(start_offset), .clr_err(clr_err)
	);

	prom_sequencer u_prom_sequencer (
		.CLK(CLK), .local_rst(local_rst),
		.seq_start(seq_start), .seq_cmd(seq_cmd), .seq_count(seq_count),
		.bpi_busy(bpi_busy), .bpi_load_data(bpi_load_data), .bpi_data_from(bpi_data_from),
		.step(step), .execute(bpi_execute), .addr_incr(addr_incr), .rbk_wr(rbk_wr),
		.sr_load(sr_load), .prom_err(prom_err), .seq_done(seq_done)
	);

	prom_cmd_map u_prom_cmd_map (
		.CLK(CLK), .local_rst(local_rst),
		.load_addr(load_addr), .base_addr(base_addr), .start_offset(start_offset),
		.addr_incr(addr_incr), .seq_cmd(seq_cmd), .step(step), .prog_data(prog_data),
		.bpi_addr(bpi_addr), .bpi_data_to(bpi_data_to), .bpi_op(bpi_op)
	);

	status_regs u_status_regs (
		.CLK(CLK), .local_rst(local_rst),
		.sr_load(sr_load), .bpi_data_from(bpi_data_from),
		.prom_err(prom_err), .clr_err(clr_err),
		.cmd_empty(cmd_empty), .cmd_full(cmd_full), .cmd_wr_err(cmd_wr_err),
		.rbk_empty(rbk_empty), .rbk_full(rbk_full),
		.rbk_wr_err(rbk_wr_err), .rbk_rd_err(rbk_rd_err),
		.bpi_status(bpi_status)
	);

endmodule

//--- logic/status_regs.sv
`timescale 1ns/1ns

module status_regs (
	input  logic                CLK,
	input  logic                local_rst,
	input  logic                sr_load,
	input  bpi_pkg::prom_data_t bpi_data_from,
	input  logic                prom_err,
	input  logic                clr_err,
	input  logic                cmd_empty,
	input  logic                cmd_full,
	input  logic                cmd_wr_err,
	input  logic                rbk_empty,
	input  logic                rbk_full,
	input  logic                rbk_wr_err,
	input  logic                rbk_rd_err,
	output logic [15:0]         bpi_status
);
	import bpi_pkg::*;

	sr_t         sr;
	logic [15:8] flags;

	// A new error beats a clear in the same cycle
	function automatic logic sticky(input logic held, input logic err, input logic clr);
		return err | (held & ~clr);
	endfunction

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			sr    <= '0;
			flags <= '0;
		end
		else
		begin
			if (sr_load)
				sr <= bpi_data_from[7:0];   // Low byte of the poll
			flags[ST_RBK_EMPTY] <= rbk_empty;
			flags[ST_RBK_FULL]  <= rbk_full;
			flags[ST_RBK_RDERR] <= sticky(flags[ST_RBK_RDERR], rbk_rd_err, clr_err);
			flags[ST_RBK_WRERR] <= sticky(flags[ST_RBK_WRERR], rbk_wr_err, clr_err);
			flags[ST_CMD_EMPTY] <= cmd_empty;
			flags[ST_CMD_FULL]  <= cmd_full;
			flags[ST_PROM_ERR]  <= sticky(flags[ST_PROM_ERR], prom_err, clr_err);
			flags[ST_CMD_WRERR] <= sticky(flags[ST_CMD_WRERR], cmd_wr_err, clr_err);
		end
	end

	assign bpi_status = {flags, sr};

endmodule

//--- logic/prom_cmd_map.sv
`timescale 1ns/1ns

module prom_cmd_map (
	input  logic                CLK,
	input  logic                local_rst,
	input  logic                load_addr,
	input  logic [6:0]          base_addr,
	input  bpi_pkg::prom_data_t start_offset,
	input  logic                addr_incr,
	input  bpi_pkg::cmd_code_t  seq_cmd,
	input  bpi_pkg::seq_step_t  step,
	input  bpi_pkg::prom_data_t prog_data,
	output bpi_pkg::prom_addr_t bpi_addr,
	output bpi_pkg::prom_data_t bpi_data_to,
	output bpi_pkg::bus_op_t    bpi_op
);
	import bpi_pkg::*;

	logic [6:0] base_q;
	prom_data_t offset_q;
	prom_addr_t cur_addr;
	prom_addr_t bank_addr;
	prom_addr_t block_addr;

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			base_q   <= '0;
			offset_q <= '0;
		end
		else if (load_addr)
		begin
			base_q   <= base_addr;
			offset_q <= start_offset;
		end
		else if (addr_incr)
			offset_q <= offset_q + 16'd1;  // Wraps inside the base
	end

	assign cur_addr  = {base_q, offset_q};
	assign bank_addr = cur_addr & BANK_MASK;
	assign block_addr = (cur_addr >= PARAM_REGION_START) ?
		(cur_addr & PARAM_BLOCK_MASK) : (cur_addr & MAIN_BLOCK_MASK);

	// Opcode and address per command and step
	always_comb
	begin
		bpi_op      = OP_WRITE;
		bpi_addr    = bank_addr;
		bpi_data_to = '0;
		case (seq_cmd)
			CMD_READ_ARRAY: bpi_data_to = OPC_READ_ARRAY;
			CMD_READ_SR:    bpi_data_to = OPC_READ_SR;
			CMD_CLR_SR:     bpi_data_to = OPC_CLR_SR;
			CMD_READ_1, CMD_READ_N:
			begin
				bpi_op   = OP_READ;
				bpi_addr = cur_addr;
			end
			CMD_BLOCK_ERASE:
			begin
				bpi_addr = block_addr;
				case (step)
					STEP_WR1:  bpi_data_to = OPC_ERASE_SETUP;
					STEP_WR2:  bpi_data_to = OPC_CONFIRM;
					STEP_POLL: bpi_op = OP_READ;   // Status poll
					default:   bpi_data_to = '0;
				endcase
			end
			CMD_PROGRAM:
			begin
				bpi_addr = cur_addr;
				case (step)
					STEP_WR1:  bpi_data_to = OPC_PROGRAM;
					STEP_WR2:  bpi_data_to = prog_data;
					STEP_POLL: bpi_op = OP_READ;
					default:   bpi_data_to = '0;
				endcase
			end
			default:        bpi_data_to = '0;
		endcase
	end

endmodule

//--- logic/prom_sequencer.sv
`timescale 1ns/1ns

module prom_sequencer (
	input  logic                CLK,
	input  logic                local_rst,
	input  logic                seq_start,
	input  bpi_pkg::cmd_code_t  seq_cmd,
	input  logic [11:0]         seq_count,
	input  logic                bpi_busy,
	input  logic                bpi_load_data,
	input  bpi_pkg::prom_data_t bpi_data_from,
	output bpi_pkg::seq_step_t  step,
	output logic                execute,
	output logic                addr_incr,
	output logic                rbk_wr,
	output logic                sr_load,
	output logic                prom_err,
	output logic                seq_done
);
	import bpi_pkg::*;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_WAIT_BUSY,
		SEQ_WAIT_DONE,
		SEQ_NEXT
	} seq_state_t;

	seq_state_t  state;
	logic [11:0] words_left;
	logic        ready;      // Ready bit of the last poll
	logic        in_cycle;
	logic        two_step;
	logic        finish;
	sr_t         poll_sr;
	sr_t         err_mask;

	assign in_cycle = (state == SEQ_WAIT_BUSY) || (state == SEQ_WAIT_DONE);
	assign poll_sr  = bpi_data_from[7:0];
	assign two_step = (seq_cmd == CMD_BLOCK_ERASE) || (seq_cmd == CMD_PROGRAM);
	assign err_mask = (seq_cmd == CMD_BLOCK_ERASE) ? ERASE_ERR_MASK : PROG_ERR_MASK;

	//////////////////////////////////////////////////
	// Bus cycle outputs
	//////////////////////////////////////////////////

	assign execute  = (state == SEQ_ISSUE);
	assign rbk_wr   = in_cycle && bpi_load_data && (step == STEP_READ);
	assign sr_load  = in_cycle && bpi_load_data && (step == STEP_POLL);
	assign prom_err = sr_load && poll_sr[SR_READY_BIT] && ((poll_sr & err_mask) != '0);

	// Last step of the command
	always_comb
	begin
		case (step)
			STEP_WR1:  finish = !two_step;
			STEP_WR2:  finish = 1'b0;
			STEP_READ: finish = (words_left == 12'd1);
			default:   finish = ready;   // Poll until ready
		endcase
	end

	assign seq_done  = (state == SEQ_NEXT) && finish;
	assign addr_incr = (state == SEQ_NEXT) &&
		((step == STEP_READ) || ((step == STEP_POLL) && ready && (seq_cmd == CMD_PROGRAM)));

	//////////////////////////////////////////////////
	// Step FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state      <= SEQ_IDLE;
			step       <= STEP_WR1;
			words_left <= '0;
			ready      <= 1'b0;
		end
		else
		begin
			if (state == SEQ_ISSUE)
				ready <= 1'b0;
			else if (sr_load)
				ready <= poll_sr[SR_READY_BIT];
			case (state)
				SEQ_IDLE:
					if (seq_start)
					begin
						words_left <= seq_count;
						if ((seq_cmd == CMD_READ_1) || (seq_cmd == CMD_READ_N))
							step <= STEP_READ;
						else
							step <= STEP_WR1;
						state <= SEQ_ISSUE;
					end
				SEQ_ISSUE:
					state <= SEQ_WAIT_BUSY;
				SEQ_WAIT_BUSY:
					if (bpi_busy)
						state <= SEQ_WAIT_DONE;  // PROM took the cycle
				SEQ_WAIT_DONE:
					if (!bpi_busy)
						state <= SEQ_NEXT;       // Falling busy ends the cycle
				SEQ_NEXT:
					if (finish)
						state <= SEQ_IDLE;
					else
					begin
						state <= SEQ_ISSUE;
						case (step)
							STEP_WR1:  step <= STEP_WR2;
							STEP_WR2:  step <= STEP_POLL;
							STEP_READ: words_left <= words_left - 12'd1;
							default:   step <= STEP_POLL;
						endcase
					end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

//--- logic/cmd_parser.sv
`timescale 1ns/1ns

module cmd_parser (
	input  logic                CLK,
	input  logic                local_rst,
	input  logic                enbl,
	input  logic                dsbl,
	input  bpi_pkg::cmd_word_t  cmd_head,
	input  logic                cmd_empty,
	input  logic                seq_done,
	output logic                cmd_pop,
	output logic                active,
	output logic                seq_start,
	output bpi_pkg::cmd_code_t  seq_cmd,
	output logic [11:0]         seq_count,
	output bpi_pkg::prom_data_t prog_data,
	output logic                load_addr,
	output logic [6:0]          base_addr,
	output bpi_pkg::prom_data_t start_offset,
	output logic                clr_err
);
	import bpi_pkg::*;

	typedef enum logic [1:0] {PARSE_IDLE, PARSE_DECODE, PARSE_EXTRA, PARSE_RUN} parse_state_t;

	parse_state_t state;
	logic         enable;
	cmd_code_t    head_code;
	cmd_arg_t     head_arg;
	cmd_arg_t     arg_q;      // Argument of the command in progress

	assign head_code = cmd_head[4:0];
	assign head_arg  = cmd_head[15:5];
	assign active    = (state != PARSE_IDLE);
	assign cmd_pop   = (state == PARSE_DECODE) || ((state == PARSE_EXTRA) && !cmd_empty);

	// Enable wins over disable
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			enable <= 1'b0;
		else if (enbl)
			enable <= 1'b1;
		else if (dsbl)
			enable <= 1'b0;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state     <= PARSE_IDLE;
			seq_cmd   <= CMD_NOOP;
			seq_start <= 1'b0;
			load_addr <= 1'b0;
			clr_err   <= 1'b0;
		end
		else
		begin
			seq_start <= 1'b0;
			load_addr <= 1'b0;
			clr_err   <= 1'b0;
			case (state)
				PARSE_IDLE:
					if (enable && !cmd_empty)
						state <= PARSE_DECODE;
				PARSE_DECODE:
				begin
					seq_cmd <= head_code;
					case (head_code)
						CMD_LOAD_ADDR, CMD_PROGRAM:
							state <= PARSE_EXTRA;  // Second word follows
						CMD_CLR_STATUS:
						begin
							clr_err <= 1'b1;
							state   <= PARSE_IDLE;
						end
						CMD_READ_1, CMD_READ_N, CMD_READ_ARRAY, CMD_READ_SR,
						CMD_CLR_SR, CMD_BLOCK_ERASE:
						begin
							seq_start <= 1'b1;
							state     <= PARSE_RUN;
						end
						default:
							state <= PARSE_IDLE;  // NoOp and unknown codes
					endcase
				end
				PARSE_EXTRA:
					if (!cmd_empty)
					begin
						if (seq_cmd == CMD_LOAD_ADDR)
						begin
							load_addr <= 1'b1;
							state     <= PARSE_IDLE;
						end
						else
						begin
							seq_start <= 1'b1;
							state     <= PARSE_RUN;
						end
					end
				PARSE_RUN:
					if (seq_done)
						state <= PARSE_IDLE;
				default:
					state <= PARSE_IDLE;
			endcase
		end
	end

	// Command arguments and extra words
	always_ff @(posedge CLK)
	begin
		if (state == PARSE_DECODE)
		begin
			arg_q     <= head_arg;
			seq_count <= (head_code == CMD_READ_N) ? {1'b0, head_arg} + 12'd1 : 12'd1;
		end
		if ((state == PARSE_EXTRA) && !cmd_empty)
		begin
			if (seq_cmd == CMD_LOAD_ADDR)
			begin
				base_addr    <= arg_q[6:0];
				start_offset <= cmd_head;
			end
			else
				prog_data <= cmd_head;
		end
	end

endmodule

//--- logic/cmd_fifo.sv
`timescale 1ns/1ns

module cmd_fifo #(
	parameter int DEPTH_LOG2 = bpi_pkg::FIFO_DEPTH_LOG2
) (
	input  logic                CLK,
	input  logic                local_rst,
	input  bpi_pkg::cmd_word_t  wr_data,
	input  logic                wr_en,
	input  logic                rd_en,
	output bpi_pkg::cmd_word_t  rd_data,
	output logic                empty,
	output logic                full,
	output bpi_pkg::fifo_cnt_t  count,
	output logic                wr_err,
	output logic                rd_err
);
	import bpi_pkg::*;

	cmd_word_t mem [2**DEPTH_LOG2];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   cnt;     // One bit wider than the pointers
	logic do_wr;
	logic do_rd;

	assign empty   = (cnt == '0);
	assign full    = cnt[DEPTH_LOG2];  // Only set at exactly full depth
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	assign wr_err  = wr_en && full;    // Dropped write
	assign rd_err  = rd_en && empty;   // Pop of an empty FIFO
	assign rd_data = mem[rd_ptr];      // Head word always visible
	assign count   = fifo_cnt_t'(cnt);

	always_ff @(posedge CLK)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;  // Idle or both at once
			endcase
		end
	end

endmodule

//--- logic/bpi_pkg.sv
package bpi_pkg;

	// Data widths
	typedef logic [15:0] cmd_word_t;
	typedef logic [4:0]  cmd_code_t;    // Low 5 bits of a command word
	typedef logic [10:0] cmd_arg_t;     // Upper 11 bits of a command word
	typedef logic [22:0] prom_addr_t;   // 7-bit base and 16-bit offset
	typedef logic [15:0] prom_data_t;
	typedef logic [7:0]  sr_t;          // PROM status register
	typedef logic [1:0]  bus_op_t;
	typedef logic [10:0] fifo_cnt_t;

	// Host command codes
	localparam cmd_code_t CMD_NOOP        = 5'h00;
	localparam cmd_code_t CMD_READ_1      = 5'h02;
	localparam cmd_code_t CMD_READ_N      = 5'h04;
	localparam cmd_code_t CMD_READ_ARRAY  = 5'h05;
	localparam cmd_code_t CMD_READ_SR     = 5'h06;
	localparam cmd_code_t CMD_CLR_SR      = 5'h09;
	localparam cmd_code_t CMD_BLOCK_ERASE = 5'h0A;
	localparam cmd_code_t CMD_PROGRAM     = 5'h0B;
	localparam cmd_code_t CMD_LOAD_ADDR   = 5'h17;  // Handled in the parser
	localparam cmd_code_t CMD_CLR_STATUS  = 5'h1C;  // Handled in the parser

	// Low-level bus operations
	localparam bus_op_t OP_READ  = 2'b10;
	localparam bus_op_t OP_WRITE = 2'b01;

	// PROM opcodes
	localparam prom_data_t OPC_READ_ARRAY  = 16'h00FF;
	localparam prom_data_t OPC_READ_SR     = 16'h0070;
	localparam prom_data_t OPC_CLR_SR      = 16'h0050;
	localparam prom_data_t OPC_ERASE_SETUP = 16'h0020;
	localparam prom_data_t OPC_CONFIRM     = 16'h00D0;
	localparam prom_data_t OPC_PROGRAM     = 16'h0040;

	// Bank and block address masks
	localparam prom_addr_t BANK_MASK          = 23'h780000;
	localparam prom_addr_t MAIN_BLOCK_MASK    = 23'h7F0000;  // 64 KWord blocks
	localparam prom_addr_t PARAM_BLOCK_MASK   = 23'h7FC000;  // 16 KWord blocks
	localparam prom_addr_t PARAM_REGION_START = 23'h7F0000;

	// PROM status register fields
	localparam sr_t ERASE_ERR_MASK = 8'h2A;
	localparam sr_t PROG_ERR_MASK  = 8'h1A;
	localparam int  SR_READY_BIT   = 7;

	localparam int FIFO_DEPTH_LOG2 = 10;

	// Host status word bit positions
	localparam int ST_RBK_EMPTY = 15;
	localparam int ST_RBK_FULL  = 14;
	localparam int ST_RBK_RDERR = 13;
	localparam int ST_RBK_WRERR = 12;
	localparam int ST_CMD_EMPTY = 11;
	localparam int ST_CMD_FULL  = 10;
	localparam int ST_PROM_ERR  = 9;
	localparam int ST_CMD_WRERR = 8;

	typedef enum logic [1:0] {STEP_WR1, STEP_WR2, STEP_READ, STEP_POLL} seq_step_t;

endpackage
